/* Makefile */
# Verilator build and run for the serial boot subsystem testbench

TOP := bootTb
SIM := obj_dir/bootSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -o bootSim

# pass only when the testbench prints its pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* hdl/bootPkg.sv */
// boot path shared definitions: memory geometry, no-op word and FSM state types
`default_nettype none

package bootPkg;

    // instruction store geometry
    localparam int memDepth    = 256;
    localparam int memAddrBits = 8;
    localparam int wordBits    = 32;

    // addi x0, x0, 0
    // returned for any fetch beyond the loaded store
    localparam logic [wordBits-1:0] nopWord = 32'h0000_0013;

    // serial receiver FSM
    typedef enum logic [1:0] {
        idle,
        startBit,
        dataBits,
        stopBit
    } rxState_t;

    // program loader FSM
    // getSize waits for the word count, getByte packs words
    typedef enum logic [1:0] {
        getSize,
        getByte,
        done
    } loadState_t;

endpackage

`default_nettype wire

/* hdl/bootTop.sv */
// serial boot subsystem top: receiver, program loader and instruction store
`timescale 1ns/10ps
`default_nettype none

module bootTop
    import bootPkg::*;
#(
    parameter int clksPerBit = 234
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                serialIn,
    input  logic [31:0]         fetchAddr,
    output logic [wordBits-1:0] fetchData,
    output logic                cpuEnable,
    output logic [5:0]          leds
);

    logic [7:0]             rxByte;
    logic                   rxValid;
    logic                   wrEn;
    logic [memAddrBits-1:0] wrAddr;
    logic [wordBits-1:0]    wrData;

    // host line to byte strobes
    uartRx #(
        .clksPerBit(clksPerBit)
    ) i_uartRx (
        .clk     (clk),
        .reset   (reset),
        .serialIn(serialIn),
        .rxByte  (rxByte),
        .rxValid (rxValid)
    );

    progLoader i_progLoader (
        .clk      (clk),
        .reset    (reset),
        .rxByte   (rxByte),
        .rxValid  (rxValid),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .cpuEnable(cpuEnable)
    );

    // core fetches from here once cpuEnable is up
    instrMem i_instrMem (
        .clk      (clk),
        .reset    (reset),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .fetchAddr(fetchAddr),
        .fetchData(fetchData),
        .leds     (leds)
    );

endmodule

`default_nettype wire

/* hdl/instrMem.sv */
// instruction store: one write port, registered fetch port with no-op default, LED mirror
`timescale 1ns/10ps
`default_nettype none

module instrMem
    import bootPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wrEn,
    input  logic [memAddrBits-1:0] wrAddr,
    input  logic [wordBits-1:0]    wrData,
    input  logic [31:0]            fetchAddr,
    output logic [wordBits-1:0]    fetchData,
    output logic [5:0]             leds
);

    logic [wordBits-1:0] mem [memDepth];
    logic                inRange;

    assign inRange = fetchAddr < 32'(memDepth);

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // read-before-write on a same-address collision
    always_ff @(posedge clk) begin
        if (inRange) begin
            fetchData <= mem[fetchAddr[memAddrBits-1:0]];
        end else begin
            fetchData <= nopWord;
        end
    end

    // LEDs are active low, so all ones is dark
    always_ff @(posedge clk) begin
        if (reset) begin
            leds <= '1;
        end else if (wrEn && wrAddr == '0) begin
            leds <= ~wrData[5:0];
        end
    end

endmodule

`default_nettype wire

/* hdl/progLoader.sv */
// program loader FSM: takes the word count, packs bytes MSB first and writes the store
`timescale 1ns/10ps
`default_nettype none

module progLoader
    import bootPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             rxByte,
    input  logic                   rxValid,
    output logic                   wrEn,
    output logic [memAddrBits-1:0] wrAddr,
    output logic [wordBits-1:0]    wrData,
    output logic                   cpuEnable
);

    // one extra bit so a full load of memDepth words can be counted
    localparam int cntBits = memAddrBits + 1;

    loadState_t         loadState;
    logic [cntBits-1:0] wordTotal;
    logic [cntBits-1:0] wordIdx;
    logic [cntBits-1:0] nextIdx;
    logic [1:0]         byteCnt;
    logic [23:0]        byteShift;
    logic               lastByte;

    assign nextIdx  = wordIdx + 1'b1;
    assign lastByte = rxValid && (loadState == getByte) && (byteCnt == 2'd3);

    always_ff @(posedge clk) begin
        if (reset) begin
            loadState <= getSize;
            wordTotal <= '0;
            wordIdx   <= '0;
            byteCnt   <= '0;
            wrEn      <= 1'b0;
            cpuEnable <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            case (loadState)
                getSize: begin
                    if (rxValid) begin
                        // a count byte of zero stands for a full store
                        if (rxByte == 8'd0) begin
                            wordTotal <= cntBits'(memDepth);
                        end else begin
                            wordTotal <= cntBits'(rxByte);
                        end
                        byteCnt   <= '0;
                        loadState <= getByte;
                    end
                end
                getByte: begin
                    if (rxValid) begin
                        byteCnt <= byteCnt + 1'b1;
                        if (byteCnt == 2'd3) begin
                            wrEn    <= 1'b1;
                            wordIdx <= nextIdx;
                            // enable the core together with the last write
                            if (nextIdx == wordTotal) begin
                                loadState <= done;
                                cpuEnable <= 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    // done: further bytes are ignored until reset
                end
            endcase
        end
    end

    // word assembly, first byte ends up in the top of the word
    always_ff @(posedge clk) begin
        if (rxValid && loadState == getByte) begin
            byteShift <= {byteShift[15:0], rxByte};
        end
        if (lastByte) begin
            wrAddr <= wordIdx[memAddrBits-1:0];
            wrData <= {byteShift, rxByte};
        end
    end

endmodule

`default_nettype wire

/* hdl/uartRx.sv */
// 8N1 UART receiver with mid-bit sampling and one strobe per well-framed byte
`timescale 1ns/10ps
`default_nettype none

module uartRx
    import bootPkg::*;
#(
    parameter int clksPerBit = 234
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       serialIn,
    output logic [7:0] rxByte,
    output logic       rxValid
);

    localparam int timerBits = $clog2(clksPerBit);
    localparam int halfBit   = clksPerBit / 2;

    localparam logic [timerBits-1:0] halfLast = timerBits'(halfBit - 1);
    localparam logic [timerBits-1:0] bitLast  = timerBits'(clksPerBit - 1);

    rxState_t             rxState;
    logic [1:0]           rxSync;
    logic                 rxPrev;
    logic                 rxIn;
    logic [timerBits-1:0] bitTimer;
    logic [2:0]           bitIdx;
    logic [7:0]           shiftReg;

    assign rxIn   = rxSync[1];
    assign rxByte = shiftReg;

    // two-flop synchronizer plus one stage for the start edge
    // line idles high, so reset to ones to avoid a false start
    always_ff @(posedge clk) begin
        if (reset) begin
            rxSync <= 2'b11;
            rxPrev <= 1'b1;
        end else begin
            rxSync <= {rxSync[0], serialIn};
            rxPrev <= rxIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rxState  <= idle;
            bitTimer <= '0;
            bitIdx   <= '0;
            rxValid  <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            case (rxState)
                idle: begin
                    // falling edge marks the start of a frame
                    if (rxPrev && !rxIn) begin
                        rxState  <= startBit;
                        bitTimer <= '0;
                    end
                end
                startBit: begin
                    if (bitTimer == halfLast) begin
                        bitTimer <= '0;
                        bitIdx   <= '0;
                        // high at mid-bit means a glitch, not a frame
                        if (rxIn) begin
                            rxState <= idle;
                        end else begin
                            rxState <= dataBits;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                dataBits: begin
                    if (bitTimer == bitLast) begin
                        bitTimer <= '0;
                        if (bitIdx == 3'd7) begin
                            rxState <= stopBit;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                stopBit: begin
                    if (bitTimer == bitLast) begin
                        bitTimer <= '0;
                        // framing error drops the byte silently
                        rxValid  <= rxIn;
                        // back to idle mid stop bit, ready for the next frame
                        rxState  <= idle;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                default: begin
                    rxState <= idle;
                end
            endcase
        end
    end

    // data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (rxState == dataBits && bitTimer == bitLast) begin
            shiftReg <= {rxIn, shiftReg[7:1]};
        end
    end

endmodule

`default_nettype wire

/* verif/bootTb.sv */
// testbench for the serial boot subsystem that drives the UART line and plays the core fetch side
`timescale 1ns/10ps
`default_nettype none

module bootTb
    import bootPkg::*;
();

    localparam int bitClks       = 16;
    localparam int enableTimeout = 4 * bitClks;

    logic                clk;
    logic                reset;
    logic                serialIn;
    logic [31:0]         fetchAddr;
    logic [wordBits-1:0] fetchData;
    logic                cpuEnable;
    logic [5:0]          leds;

    // program words under test, each sent MSB first
    logic [wordBits-1:0] prog [memDepth];
    int                  errCount;
    int                  testCount;
    int                  testFails;

    bootTop #(
        .clksPerBit(bitClks)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .serialIn (serialIn),
        .fetchAddr(fetchAddr),
        .fetchData(fetchData),
        .cpuEnable(cpuEnable),
        .leds     (leds)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        reset    = 1'b1;
        serialIn = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // start, 8 data bits LSB first, stop
    task automatic sendByte(input logic [7:0] data, input logic badStop);
        int i;
        serialIn = 1'b0;
        repeat (bitClks) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            serialIn = data[i];
            repeat (bitClks) @(negedge clk);
        end
        serialIn = !badStop;
        repeat (bitClks) @(negedge clk);
        // idle high again so the next start edge is seen
        if (badStop) begin
            serialIn = 1'b1;
            repeat (bitClks) @(negedge clk);
        end
    endtask

    task automatic waitEnable();
        int n;
        n = 0;
        while (!cpuEnable && n < enableTimeout) begin
            @(negedge clk);
            n++;
        end
        if (!cpuEnable) begin
            $display("ERROR at %0t ns: timeout, cpuEnable still low after %0d cycles",
                     $time, enableTimeout);
            errCount++;
        end
    endtask

    task automatic fillRandom(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            prog[i] = $urandom();
        end
    endtask

    // count byte, optional framing-error byte, then the words
    task automatic loadProgram(input int count, input logic badFirst);
        int w;
        int b;
        sendByte(8'(count), 1'b0);
        if (badFirst) begin
            sendByte(8'($urandom()), 1'b1);
        end
        for (w = 0; w < count; w++) begin
            for (b = 3; b >= 0; b--) begin
                checkValue(32'(cpuEnable), 32'd0, "cpuEnable before last byte");
                sendByte(prog[w][8*b +: 8], 1'b0);
            end
        end
        waitEnable();
    endtask

    task automatic fetch(input logic [31:0] addr, output logic [wordBits-1:0] data);
        fetchAddr = addr;
        @(negedge clk);
        data = fetchData;
    endtask

    task automatic checkProgram(input int count);
        int i;
        logic [wordBits-1:0] got;
        for (i = 0; i < count; i++) begin
            fetch(32'(i), got);
            checkValue(got, prog[i], $sformatf("fetch of word %0d", i));
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testCount++;
        if (errCount != errsBefore) begin
            testFails++;
            $display("test %s: fail", name);
        end else begin
            $display("test %s: pass", name);
        end
    endtask

    task automatic loadWordsTest();
        int errsBefore;
        errsBefore = errCount;
        applyReset();
        fillRandom(5);
        loadProgram(5, 1'b0);
        checkProgram(5);
        reportTest("load of 5 words", errsBefore);
    endtask

    task automatic outOfRangeTest();
        int errsBefore;
        logic [31:0] addr;
        logic [wordBits-1:0] got;
        errsBefore = errCount;
        applyReset();
        fetch(32'd256, got);
        checkValue(got, nopWord, "fetch of address 256");
        addr = $urandom();
        if (addr <= 32'd256) begin
            addr = addr + 32'd257;
        end
        fetch(addr, got);
        checkValue(got, nopWord, $sformatf("fetch of address %h", addr));
        reportTest("out of range fetch", errsBefore);
    endtask

    task automatic ledMirrorTest();
        int errsBefore;
        logic [5:0] ledExp;
        errsBefore = errCount;
        applyReset();
        checkValue(32'(leds), 32'h3f, "leds after reset");
        fillRandom(1);
        loadProgram(1, 1'b0);
        // active low mirror of word 0
        ledExp = ~prog[0][5:0];
        checkValue(32'(leds), 32'(ledExp), "leds after word 0");
        reportTest("led mirror", errsBefore);
    endtask

    task automatic enableTimingTest();
        int errsBefore;
        int i;
        errsBefore = errCount;
        applyReset();
        fillRandom(2);
        loadProgram(2, 1'b0);
        // extra traffic once loading is done
        for (i = 0; i < 8; i++) begin
            sendByte(8'($urandom()), 1'b0);
        end
        checkValue(32'(cpuEnable), 32'd1, "cpuEnable after extra bytes");
        checkProgram(2);
        reportTest("enable timing", errsBefore);
    endtask

    task automatic badStopTest();
        int errsBefore;
        errsBefore = errCount;
        applyReset();
        fillRandom(2);
        loadProgram(2, 1'b1);
        checkProgram(2);
        reportTest("bad stop bit", errsBefore);
    endtask

    task automatic midResetTest();
        int errsBefore;
        int i;
        errsBefore = errCount;
        applyReset();
        fillRandom(4);
        sendByte(8'd4, 1'b0);
        // one full word plus half of the next
        for (i = 0; i < 6; i++) begin
            sendByte(prog[i / 4][8*(3 - i % 4) +: 8], 1'b0);
        end
        applyReset();
        checkValue(32'(cpuEnable), 32'd0, "cpuEnable after mid-load reset");
        checkValue(32'(leds), 32'h3f, "leds after mid-load reset");
        fillRandom(3);
        loadProgram(3, 1'b0);
        checkProgram(3);
        reportTest("reset during load", errsBefore);
    endtask

    initial begin
        errCount  = 0;
        testCount = 0;
        testFails = 0;
        reset     = 1'b1;
        serialIn  = 1'b1;
        fetchAddr = '0;
        void'($urandom(44087));

        loadWordsTest();
        outOfRangeTest();
        ledMirrorTest();
        enableTimingTest();
        badStopTest();
        midResetTest();

        $display("tests run: %0d, tests failed: %0d, checks failed: %0d",
                 testCount, testFails, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/bootTop_sva.sv */
// boot path protocol checks: single-cycle strobes, sticky enable, no repeated writes
`timescale 1ns/10ps
`default_nettype none

module bootTopSva
    import bootPkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic                   rxValid,
    input logic                   wrEn,
    input logic [memAddrBits-1:0] wrAddr,
    input logic                   cpuEnable
);

    // one bit per store address, set once it has been written
    logic [memDepth-1:0] written;

    always_ff @(posedge clk) begin
        if (reset) begin
            written <= '0;
        end else if (wrEn) begin
            written[wrAddr] <= 1'b1;
        end
    end

    rxValidSingle: assert property (@(posedge clk) disable iff (reset) rxValid |=> !rxValid)
        else $error("rxValid high for two cycles in a row");

    wrEnSingle: assert property (@(posedge clk) disable iff (reset) wrEn |=> !wrEn)
        else $error("wrEn high for two cycles in a row");

    // enable may only drop as a result of reset
    enableSticky: assert property (@(posedge clk) $fell(cpuEnable) |-> $past(reset))
        else $error("cpuEnable fell without reset");

    wrAddrUnique: assert property (@(posedge clk) disable iff (reset) wrEn |-> !written[wrAddr])
        else $error("wrAddr written twice since reset");

endmodule

bind bootTop bootTopSva i_sva (
    .clk      (clk),
    .reset    (reset),
    .rxValid  (rxValid),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .cpuEnable(cpuEnable)
);

`default_nettype wire

/* vlog.f */
hdl/bootPkg.sv
hdl/uartRx.sv
hdl/progLoader.sv
hdl/instrMem.sv
hdl/bootTop.sv
verif/bootTop_sva.sv
verif/bootTb.sv
